// ==== logic/addr_pkg.sv ====
`default_nettype none

package addr_pkg;

    // Instruction byte address
    typedef logic [31:0] pc_t;

    // Byte offset inside one cache line
    typedef logic [5:0] line_off_t;

    // Cache line geometry
    localparam int LINE_BYTES = 64;
    localparam int INST_BYTES = 4;

    // Number of offset bits, kept in step with line_off_t
    localparam int LINE_OFF_W = $bits(line_off_t);

endpackage

`default_nettype wire

// ==== logic/ftq_pkg.sv ====
`default_nettype none

package ftq_pkg;

    // Instruction count of a fetch block or of one line request
    // 4 bits covers FETCH_WIDTH up to 15
    typedef logic [3:0] inst_cnt_t;

    // Splitter position inside a block
    typedef enum logic {
        SPLIT_FIRST  = 1'b0,
        SPLIT_SECOND = 1'b1
    } split_state_t;

endpackage

`default_nettype wire

// ==== logic/fetch_block_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_block_gen
    import addr_pkg::*;
#(
    parameter int FETCH_WIDTH = 4
) (
    input  wire logic clk,
    input  wire logic rst_n,

    // Redirect, loads a new stream start
    input  wire logic flush_i,
    input  wire pc_t  redirect_pc_i,

    // Block stream towards the FTQ
    output logic      blk_valid_o,
    input  wire logic blk_ready_i,
    output pc_t       blk_pc_o,
    output logic      blk_cross_o
);

    // Bytes covered by one fetch block
    localparam int BLK_BYTES = FETCH_WIDTH * INST_BYTES;

    pc_t       next_pc;
    logic      active;
    logic      blk_fire;
    line_off_t blk_off;

    assign blk_fire = blk_valid_o && blk_ready_i;

    // Stream becomes live on the first redirect after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
        end else if (flush_i) begin
            active <= 1'b1;
        end
    end

    // Next block PC, a redirect wins over a handshake in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            next_pc <= '0;
        end else if (flush_i) begin
            next_pc <= redirect_pc_i;
        end else if (blk_fire) begin
            next_pc <= next_pc + pc_t'(BLK_BYTES);
        end
    end

    assign blk_valid_o = active;
    assign blk_pc_o    = next_pc;

    // Crossing check from the start offset within the line
    assign blk_off     = blk_pc_o[LINE_OFF_W-1:0];
    assign blk_cross_o = (int'(blk_off) + BLK_BYTES) > LINE_BYTES;

    // Offered block holds until the FTQ takes it
    property p_blk_stable;
        @(posedge clk) disable iff (!rst_n)
        (blk_valid_o && !blk_ready_i && !flush_i) |=> (blk_valid_o && $stable(blk_pc_o));
    endproperty

    a_blk_stable: assert property (p_blk_stable)
        else $error("blk_pc_o changed while waiting for blk_ready_i");

endmodule

`default_nettype wire

// ==== logic/ftq.sv ====
`timescale 1ns/10ps
`default_nettype none

module ftq
    import addr_pkg::*;
#(
    parameter int FETCH_WIDTH = 4,
    parameter int QUEUE_SIZE  = 4
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic flush_i,

    // Backend retires the oldest fetched block
    input  wire logic commit_i,

    // Write side, from the block generator
    input  wire logic blk_valid_i,
    input  wire pc_t  blk_pc_i,
    input  wire logic blk_cross_i,
    output logic      blk_ready_o,

    // Read side, towards the request splitter
    output logic      head_valid_o,
    output pc_t       head_pc_o,
    output logic      head_cross_o,
    input  wire logic head_accept_i
);

    // QUEUE_SIZE is a power of two, so pointers wrap on their own
    localparam int PTR_W = $clog2(QUEUE_SIZE);
    localparam int CNT_W = $clog2(QUEUE_SIZE + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    // Entry payload
    pc_t  entry_pc    [QUEUE_SIZE];
    logic entry_cross [QUEUE_SIZE];

    ptr_t wr_ptr;
    ptr_t fe_ptr;

    // occ_cnt counts written but not yet committed entries
    cnt_t occ_cnt;
    // fet_cnt counts the fetched part of those
    cnt_t fet_cnt;

    logic push;

    assign blk_ready_o = occ_cnt < cnt_t'(QUEUE_SIZE);
    assign push        = blk_valid_i && blk_ready_o;

    always_ff @(posedge clk) begin
        if (push) begin
            entry_pc[wr_ptr]    <= blk_pc_i;
            entry_cross[wr_ptr] <= blk_cross_i;
        end
    end

    // Pointer and count update, flush clears everything
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            fe_ptr  <= '0;
            occ_cnt <= '0;
            fet_cnt <= '0;
        end else if (flush_i) begin
            wr_ptr  <= '0;
            fe_ptr  <= '0;
            occ_cnt <= '0;
            fet_cnt <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (head_accept_i) begin
                fe_ptr <= fe_ptr + 1'b1;
            end
            occ_cnt <= occ_cnt + cnt_t'(push) - cnt_t'(commit_i);
            fet_cnt <= fet_cnt + cnt_t'(head_accept_i) - cnt_t'(commit_i);
        end
    end

    // Something written that the splitter has not taken yet
    assign head_valid_o = occ_cnt != fet_cnt;
    assign head_pc_o    = entry_pc[fe_ptr];
    assign head_cross_o = entry_cross[fe_ptr];

    // Backend may only retire blocks that were already fetched
    a_commit_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        commit_i |-> (fet_cnt != '0))
        else $error("commit_i with no fetched block outstanding");

    a_occ_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        occ_cnt <= cnt_t'(QUEUE_SIZE))
        else $error("FTQ occupancy above QUEUE_SIZE");

endmodule

`default_nettype wire

// ==== logic/ifu_req_split.sv ====
`timescale 1ns/10ps
`default_nettype none

module ifu_req_split
    import addr_pkg::*;
    import ftq_pkg::*;
#(
    parameter int FETCH_WIDTH = 4
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic flush_i,

    // Head of the FTQ
    input  wire logic head_valid_i,
    input  wire pc_t  head_pc_i,
    input  wire logic head_cross_i,
    output logic      head_accept_o,

    // Line request towards the instruction cache
    output logic      req_valid_o,
    input  wire logic req_ready_i,
    output pc_t       req_pc_o,
    output inst_cnt_t req_cnt_o,
    output logic      req_last_o
);

    split_state_t state;
    line_off_t    head_off;
    inst_cnt_t    first_cnt;
    inst_cnt_t    second_cnt;
    pc_t          second_pc;
    logic         req_fire;

    // Instructions that fit before the end of the first line
    assign head_off   = head_pc_i[LINE_OFF_W-1:0];
    assign first_cnt  = head_cross_i ?
                        inst_cnt_t'((LINE_BYTES - int'(head_off)) / INST_BYTES) :
                        inst_cnt_t'(FETCH_WIDTH);
    assign second_cnt = inst_cnt_t'(FETCH_WIDTH) - first_cnt;

    // Start of the following line
    assign second_pc  = (head_pc_i & ~pc_t'(LINE_BYTES - 1)) + pc_t'(LINE_BYTES);

    // Head stays valid in SPLIT_SECOND since it is not yet accepted
    assign req_valid_o = head_valid_i;

    always_comb begin
        if (state == SPLIT_FIRST) begin
            req_pc_o   = head_pc_i;
            req_cnt_o  = first_cnt;
            req_last_o = !head_cross_i;
        end else begin
            req_pc_o   = second_pc;
            req_cnt_o  = second_cnt;
            req_last_o = 1'b1;
        end
    end

    assign req_fire      = req_valid_o && req_ready_i;
    assign head_accept_o = req_fire && req_last_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= SPLIT_FIRST;
        end else if (flush_i) begin
            state <= SPLIT_FIRST;
        end else if (req_fire) begin
            // Last request of a block always returns to the first half
            state <= req_last_o ? SPLIT_FIRST : SPLIT_SECOND;
        end
    end

    // Stalled request must not move, the FTQ head has to hold as well
    property p_req_stable;
        @(posedge clk) disable iff (!rst_n)
        (req_valid_o && !req_ready_i && !flush_i) |=>
            (req_valid_o && $stable(req_pc_o) && $stable(req_cnt_o) && $stable(req_last_o));
    endproperty

    a_req_stable: assert property (p_req_stable)
        else $error("request changed under back-pressure in state %s", state.name());

endmodule

`default_nettype wire

// ==== logic/frontend_fetch_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module frontend_fetch_top
    import addr_pkg::*;
    import ftq_pkg::*;
#(
    parameter int FETCH_WIDTH = 4,
    parameter int QUEUE_SIZE  = 4
) (
    input  wire logic      clk,
    input  wire logic      rst_n,

    // Redirect from the backend
    input  wire logic      redirect_valid_i,
    input  wire pc_t       redirect_pc_i,

    // Commit of the oldest fetched block
    input  wire logic      commit_i,

    // Fetch request port
    output logic           req_valid_o,
    input  wire logic      req_ready_i,
    output pc_t            req_pc_o,
    output inst_cnt_t      req_cnt_o,
    output logic           req_last_o
);

    // Generator to FTQ
    logic blk_valid;
    logic blk_ready;
    pc_t  blk_pc;
    logic blk_cross;

    // FTQ to splitter
    logic head_valid;
    pc_t  head_pc;
    logic head_cross;
    logic head_accept;

    fetch_block_gen #(
        .FETCH_WIDTH (FETCH_WIDTH)
    ) u_fetch_block_gen (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (redirect_valid_i),
        .redirect_pc_i (redirect_pc_i),
        .blk_valid_o   (blk_valid),
        .blk_ready_i   (blk_ready),
        .blk_pc_o      (blk_pc),
        .blk_cross_o   (blk_cross)
    );

    ftq #(
        .FETCH_WIDTH (FETCH_WIDTH),
        .QUEUE_SIZE  (QUEUE_SIZE)
    ) u_ftq (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (redirect_valid_i),
        .commit_i      (commit_i),
        .blk_valid_i   (blk_valid),
        .blk_pc_i      (blk_pc),
        .blk_cross_i   (blk_cross),
        .blk_ready_o   (blk_ready),
        .head_valid_o  (head_valid),
        .head_pc_o     (head_pc),
        .head_cross_o  (head_cross),
        .head_accept_i (head_accept)
    );

    ifu_req_split #(
        .FETCH_WIDTH (FETCH_WIDTH)
    ) u_ifu_req_split (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (redirect_valid_i),
        .head_valid_i  (head_valid),
        .head_pc_i     (head_pc),
        .head_cross_i  (head_cross),
        .head_accept_o (head_accept),
        .req_valid_o   (req_valid_o),
        .req_ready_i   (req_ready_i),
        .req_pc_o      (req_pc_o),
        .req_cnt_o     (req_cnt_o),
        .req_last_o    (req_last_o)
    );

endmodule

`default_nettype wire

// ==== dv/frontend_fetch_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module frontend_fetch_tb
    import addr_pkg::*;
    import ftq_pkg::*;
#(
    parameter int FETCH_WIDTH = 4,
    parameter int QUEUE_SIZE  = 4
) ();

    localparam time CLK_PERIOD  = 40ns;
    localparam int  NUM_CASES   = 6;
    localparam int  REQ_TIMEOUT = 200;
    localparam int  IDLE_WINDOW = 16;
    localparam int  SEED        = 72638;

    // One row of the stimulus table
    typedef struct packed {
        pc_t        pc;
        logic [7:0] nblk;
        logic       hold;
        logic [7:0] stall_pct;
    } case_t;

    logic      clk;
    logic      rst_n;
    logic      redirect_valid;
    pc_t       redirect_pc;
    logic      commit;
    logic      req_valid;
    logic      req_ready;
    pc_t       req_pc;
    inst_cnt_t req_cnt;
    logic      req_last;

    case_t        cases [NUM_CASES];
    pc_t          exp_pc [$];
    inst_cnt_t    exp_cnt [$];
    logic         exp_last [$];
    split_state_t exp_state;

    // Blocks fetched by the DUT and not yet committed
    int          pending;
    logic        commit_en;
    int unsigned stall_pct;
    int unsigned seed_dummy;

    // Outputs as seen on the last falling edge
    logic      obs_valid;
    logic      obs_fire;
    pc_t       obs_pc;
    inst_cnt_t obs_cnt;
    logic      obs_last;

    frontend_fetch_top #(
        .FETCH_WIDTH (FETCH_WIDTH),
        .QUEUE_SIZE  (QUEUE_SIZE)
    ) u_frontend_fetch_top (
        .clk              (clk),
        .rst_n            (rst_n),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .commit_i         (commit),
        .req_valid_o      (req_valid),
        .req_ready_i      (req_ready),
        .req_pc_o         (req_pc),
        .req_cnt_o        (req_cnt),
        .req_last_o       (req_last)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_pc(input string name, input pc_t exp, input pc_t act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected 0x%08h, got 0x%08h (%s request)",
                     $time, name, exp, act, exp_state.name());
            abort_run();
        end
    endtask

    task automatic check_cnt(input string name, input inst_cnt_t exp, input inst_cnt_t act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %0d, got %0d (%s request)",
                     $time, name, exp, act, exp_state.name());
            abort_run();
        end
    endtask

    task automatic check_last(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %b, got %b (%s request)",
                     $time, name, exp, act, exp_state.name());
            abort_run();
        end
    endtask

    task automatic load_cases();
        // Aligned, near line end, random stalls, full queue, mid-stream redirects
        cases[0] = '{pc: 32'h0000_1000, nblk: 8'd6, hold: 1'b0, stall_pct: 8'd0};
        cases[1] = '{pc: 32'h0000_2038, nblk: 8'd5, hold: 1'b0, stall_pct: 8'd0};
        cases[2] = '{pc: 32'h0000_3034, nblk: 8'd8, hold: 1'b0, stall_pct: 8'd40};
        cases[3] = '{pc: 32'h0000_4000, nblk: 8'(QUEUE_SIZE + 3), hold: 1'b1,
                     stall_pct: 8'd20};
        cases[4] = '{pc: 32'h0000_503c, nblk: 8'd6, hold: 1'b0, stall_pct: 8'd30};
        cases[5] = '{pc: 32'h0000_6010, nblk: 8'd3, hold: 1'b0, stall_pct: 8'd0};
    endtask

    // Expected request stream from the block and split rules
    task automatic build_model(input pc_t start, input int nblk);
        pc_t       pc;
        int        off;
        int        b;
        inst_cnt_t first;
        exp_pc.delete();
        exp_cnt.delete();
        exp_last.delete();
        pc = start;
        for (b = 0; b < nblk; b++) begin
            off = int'(pc % pc_t'(LINE_BYTES));
            if (off + FETCH_WIDTH * INST_BYTES > LINE_BYTES) begin
                first = inst_cnt_t'((LINE_BYTES - off) / INST_BYTES);
                exp_pc.push_back(pc);
                exp_cnt.push_back(first);
                exp_last.push_back(1'b0);
                exp_pc.push_back(pc - pc_t'(off) + pc_t'(LINE_BYTES));
                exp_cnt.push_back(inst_cnt_t'(FETCH_WIDTH) - first);
                exp_last.push_back(1'b1);
            end else begin
                exp_pc.push_back(pc);
                exp_cnt.push_back(inst_cnt_t'(FETCH_WIDTH));
                exp_last.push_back(1'b1);
            end
            pc = pc + pc_t'(FETCH_WIDTH * INST_BYTES);
        end
    endtask

    // Sample on the falling edge, then drive the next cycle's inputs
    task automatic drive_cycle();
        logic do_commit;
        @(negedge clk);
        obs_valid = req_valid;
        obs_pc    = req_pc;
        obs_cnt   = req_cnt;
        obs_last  = req_last;
        // A block accepted at the coming edge is not yet committable
        do_commit = commit_en && (pending > 0) && ($urandom_range(2) == 0);
        commit    = do_commit;
        req_ready = ($urandom_range(99) >= stall_pct);
        // Handshake of the sampled request at the coming edge
        obs_fire  = obs_valid && req_ready;
        if (obs_fire && obs_last) begin
            pending++;
        end
        if (do_commit) begin
            pending--;
        end
    endtask

    task automatic apply_redirect(input pc_t pc);
        @(negedge clk);
        redirect_valid = 1'b1;
        redirect_pc    = pc;
        req_ready      = 1'b0;
        commit         = 1'b0;
        @(negedge clk);
        redirect_valid = 1'b0;
        pending        = 0;
        exp_state      = SPLIT_FIRST;
    endtask

    task automatic collect_blocks(input int nblocks);
        int   done;
        int   waited;
        logic last;
        done = 0;
        while (done < nblocks) begin
            waited = 0;
            drive_cycle();
            while (!obs_fire && waited < REQ_TIMEOUT) begin
                waited++;
                drive_cycle();
            end
            if (!obs_fire) begin
                $display("Timeout: no request was accepted within %0d cycles", REQ_TIMEOUT);
                abort_run();
            end else begin
                last = exp_last.pop_front();
                check_pc("req_pc_o", exp_pc.pop_front(), obs_pc);
                check_cnt("req_cnt_o", exp_cnt.pop_front(), obs_cnt);
                check_last("req_last_o", last, obs_last);
                exp_state = last ? SPLIT_FIRST : SPLIT_SECOND;
                if (last) begin
                    done++;
                end
            end
        end
    endtask

    // FTQ full and nothing committed, so no request may show up
    task automatic check_idle(input int cycles);
        int k;
        for (k = 0; k < cycles; k++) begin
            drive_cycle();
            check_last("req_valid_o", 1'b0, obs_valid);
        end
    endtask

    initial begin
        int c;
        rst_n          = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        commit         = 1'b0;
        req_ready      = 1'b0;
        pending        = 0;
        commit_en      = 1'b0;
        stall_pct      = 0;
        exp_state      = SPLIT_FIRST;
        seed_dummy     = $urandom(SEED);
        load_cases();

        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        for (c = 0; c < NUM_CASES; c++) begin
            apply_redirect(cases[c].pc);
            build_model(cases[c].pc, int'(cases[c].nblk));
            stall_pct = cases[c].stall_pct;
            if (cases[c].hold) begin
                commit_en = 1'b0;
                collect_blocks(QUEUE_SIZE);
                check_idle(IDLE_WINDOW);
                commit_en = 1'b1;
                collect_blocks(int'(cases[c].nblk) - QUEUE_SIZE);
            end else begin
                commit_en = 1'b1;
                collect_blocks(int'(cases[c].nblk));
            end
            $display("case %0d from 0x%08h done", c, cases[c].pc);
        end

        @(negedge clk);
        req_ready = 1'b0;
        commit    = 1'b0;
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
logic/addr_pkg.sv
logic/ftq_pkg.sv
logic/fetch_block_gen.sv
logic/ftq.sv
logic/ifu_req_split.sv
logic/frontend_fetch_top.sv
dv/frontend_fetch_tb.sv
